// ==== verif/fp_sincos_cases.txt ====
// Columns: case number, operand, expected sine, expected cosine (binary32 hex)
// Angles in radians, operands above pi or not finite expect the quiet NaN
00 00000000 00000000 3F800000
01 80000000 80000000 3F800000
02 3F800000 3F576AA4 3F0A5140
03 BF800000 BF576AA4 3F0A5140
04 3F000000 3EF57744 3F60A940
05 BF000000 BEF57744 3F60A940
06 3E800000 3E7D5777 3F780AA5
07 3FC00000 3F7F5BD5 3D90DEAA
08 40000000 3F68C7B7 BED51133
09 C0000000 BF68C7B7 BED51133
0a 40200000 3F193578 BF4D17BF
0b 40400000 3E1081C3 BF7D7026
0c C0400000 BE1081C3 BF7D7026
0d 7F800000 7FC00000 7FC00000
0e FF800000 7FC00000 7FC00000
0f 7FC00000 7FC00000 7FC00000
10 40490FF9 7FC00000 7FC00000
11 C0800000 7FC00000 7FC00000
12 42C80000 7FC00000 7FC00000

// ==== fp_sincos.f ====
logic/fp_sincos_pkg.sv
logic/fp_angle_prep.sv
logic/cordic_rotator.sv
logic/fp_pack_round.sv
logic/fp_sincos.sv
verif/fp_sincos_sva.sv
verif/fp_sincos_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then decide from the log
verilator --binary --timing --assert -Wno-fatal -f fp_sincos.f \
	--top-module fp_sincos_tb --Mdir obj_dir -o fp_sincos_sim > build.log 2>&1 &&
./obj_dir/fp_sincos_sim > sim.log 2>&1 ||
{ echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "Test failures found" sim.log &&
{ echo "Simulation reported failures, see sim.log"; exit 1; } ||
{ echo "Simulation passed"; exit 0; }

// ==== verif/fp_sincos_tb.sv ====
module fp_sincos_tb;
	import fp_sincos_pkg::*;

	// =========================================================================
	// Run parameters
	// =========================================================================

	localparam int N_CASES = 19;
	localparam int RESET_CYCLES = 16;
	// Idle cycles watched after each done_o for a stray second pulse
	localparam int WATCH_CYCLES = 12;
	localparam int MAX_GAP = 7;
	// Load cycle, latency, watch window and the longest random gap per case
	localparam int CASE_CYCLES = 1 + SINCOS_LATENCY + WATCH_CYCLES + MAX_GAP;
	localparam int CYCLE_LIMIT = N_CASES * CASE_CYCLES + RESET_CYCLES + 100;
	// Absolute error allowed on a finite result, 2**-22
	localparam real TOL = 1.0 / 4194304.0;
	// Below 2**-20 the sign of a result is not checked
	localparam real SIGN_LIMIT = 1.0 / 1048576.0;

	logic  clk;
	logic  rst;
	logic  ld_i;
	fp32_t a_i;
	fp32_t sin_o;
	fp32_t cos_o;
	logic  done_o;
	logic  busy_o;

	// Four words per case: number, operand, sine, cosine
	logic [31:0] case_words [0:4*N_CASES-1];
	logic [31:0] rng_state;
	int          error_count;
	int          cycle_count;
	int          done_count;

	fp_sincos dut (
		.clk   (clk),
		.rst   (rst),
		.ld_i  (ld_i),
		.a_i   (a_i),
		.sin_o (sin_o),
		.cos_o (cos_o),
		.done_o(done_o),
		.busy_o(busy_o)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// Watchdog over the whole run
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
			$display("Test failures found");
			$finish;
		end
	end

	// Outputs are settled by the falling edge
	always @(negedge clk) begin
		if (!rst && done_o)
			done_count++;
	end

	// 32-bit xorshift, used for idle gaps and dropped operands
	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	// NaN expectations must match bit for bit, finite ones within TOL
	task automatic check_result(input int num, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		real e_val;
		real a_val;
		real diff;
		if (expected[30:23] == 8'hFF) begin
			if (actual !== expected) begin
				$display("Error: case %0d %s expected %08h actual %08h",
					num, what, expected, actual);
				error_count++;
			end
		end else begin
			e_val = $bitstoshortreal(expected);
			a_val = $bitstoshortreal(actual);
			diff = (e_val > a_val) ? e_val - a_val : a_val - e_val;
			if (actual[30:23] == 8'hFF) begin
				$display("Error: case %0d %s expected %08h actual %08h",
					num, what, expected, actual);
				error_count++;
			end else if ((e_val > SIGN_LIMIT || e_val < -SIGN_LIMIT) &&
				expected[31] != actual[31]) begin
				$display("Error: case %0d %s sign expected %08h actual %08h",
					num, what, expected, actual);
				error_count++;
			end else if (diff > TOL) begin
				$display("Error: case %0d %s expected %08h actual %08h",
					num, what, expected, actual);
				error_count++;
			end
		end
	endtask

	// Entered and left just after a rising edge
	task automatic run_case(input int idx);
		int    num;
		fp32_t exp_sin;
		fp32_t exp_cos;
		int    waited;
		int    gap;
		logic  drop;
		num = int'(case_words[4*idx]);
		exp_sin = case_words[4*idx+2];
		exp_cos = case_words[4*idx+3];
		// Odd cases also try a second load while the first is in flight
		drop = idx[0];
		if (num != idx) begin
			$display("Cases file entry %0d carries case number %0d", idx, num);
			error_count++;
		end
		ld_i = 1'b1;
		a_i = case_words[4*idx+1];
		@(posedge clk);
		#2;
		ld_i = 1'b0;
		waited = 0;
		while (!done_o && waited <= SINCOS_LATENCY + 10) begin
			if (!busy_o) begin
				$display("Case %0d: busy_o low %0d cycles after the load", num, waited);
				error_count++;
			end
			// Lands 10 cycles after the first load and must be ignored
			if (drop && waited == 9) begin
				ld_i = 1'b1;
				a_i = next_random();
			end
			@(posedge clk);
			#2;
			ld_i = 1'b0;
			waited++;
		end
		if (!done_o) begin
			$display("Case %0d: done_o never arrived after the load", num);
			error_count++;
		end else begin
			// A done_o seen here is sampled at the next rising edge
			if (waited + 1 != SINCOS_LATENCY) begin
				$display("Error: case %0d latency expected %0d actual %0d",
					num, SINCOS_LATENCY, waited + 1);
				error_count++;
			end
			check_result(num, "sin", exp_sin, sin_o);
			check_result(num, "cos", exp_cos, cos_o);
		end
		// A dropped load would pulse done_o inside this window
		repeat (WATCH_CYCLES) begin
			@(posedge clk);
			#2;
			if (done_o) begin
				$display("Case %0d: extra done_o after the result", num);
				error_count++;
			end
		end
		gap = int'(next_random() % 32'd8);
		repeat (gap) begin
			@(posedge clk);
			#2;
		end
	endtask

	// =========================================================================
	// Main sequence
	// =========================================================================

	initial begin
		rst = 1'b1;
		ld_i = 1'b0;
		a_i = '0;
		rng_state = 32'd81;
		error_count = 0;
		cycle_count = 0;
		done_count = 0;
		$readmemh("verif/fp_sincos_cases.txt", case_words);
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst = 1'b0;
		for (int i = 0; i < N_CASES; i++)
			run_case(i);
		if (done_count != N_CASES) begin
			$display("done_o pulsed %0d times for %0d accepted loads", done_count, N_CASES);
			error_count++;
		end
		$display("Summary: %0d cases run, %0d errors", N_CASES, error_count);
		if (error_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== verif/fp_sincos_sva.sv ====
module fp_sincos_sva (
	input logic clk,
	input logic rst,
	input logic ld_i,
	input logic busy_o,
	input logic done_o
);
	import fp_sincos_pkg::*;

	// =========================================================================
	// Strobe and latency rules
	// =========================================================================

	// done_o is a single-cycle pulse
	done_single: assert property (@(posedge clk) disable iff (rst) done_o |=> !done_o)
		else $error("done_o stayed high for two cycles");

	// A load taken while idle returns exactly SINCOS_LATENCY cycles later
	done_latency: assert property (@(posedge clk) disable iff (rst)
		(ld_i && !busy_o) |-> ##SINCOS_LATENCY done_o)
		else $error("done_o missing at the fixed latency after a load");

	// The unit comes out of reset idle
	busy_after_reset: assert property (@(posedge clk) $fell(rst) |-> !busy_o)
		else $error("busy_o high at reset release");

endmodule

bind fp_sincos fp_sincos_sva u_sva (
	.clk   (clk),
	.rst   (rst),
	.ld_i  (ld_i),
	.busy_o(busy_o),
	.done_o(done_o)
);

// ==== logic/fp_sincos.sv ====
module fp_sincos (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 ld_i,
	input  fp_sincos_pkg::fp32_t a_i,
	output fp_sincos_pkg::fp32_t sin_o,
	output fp_sincos_pkg::fp32_t cos_o,
	output logic                 done_o,
	output logic                 busy_o
);
	import fp_sincos_pkg::*;

	prep_t prep;
	logic  prep_vld;
	rot_t  rot;
	logic  rot_vld;
	logic  rot_busy;

	// Loads seen while busy are dropped
	logic  ld_go;
	// Covers the two input-side cycles before the rotator takes over busy
	logic  ld_pend;

	assign ld_go  = ld_i & ~busy_o;
	assign busy_o = ld_pend | rot_busy;

	always_ff @(posedge clk) begin
		if (rst)
			ld_pend <= 1'b0;
		else if (ld_go)
			ld_pend <= 1'b1;
		else if (prep_vld)
			ld_pend <= 1'b0;
	end

	fp_angle_prep u_prep (
		.clk       (clk),
		.rst       (rst),
		.ld_i      (ld_go),
		.a_i       (a_i),
		.prep_o    (prep),
		.prep_vld_o(prep_vld)
	);

	cordic_rotator u_rot (
		.clk       (clk),
		.rst       (rst),
		.prep_i    (prep),
		.prep_vld_i(prep_vld),
		.rot_o     (rot),
		.rot_vld_o (rot_vld),
		.busy_o    (rot_busy)
	);

	fp_pack_round u_pack (
		.clk      (clk),
		.rst      (rst),
		.rot_i    (rot),
		.rot_vld_i(rot_vld),
		.sin_o    (sin_o),
		.cos_o    (cos_o),
		.done_o   (done_o)
	);

endmodule

// ==== logic/fp_pack_round.sv ====
module fp_pack_round (
	input  logic                 clk,
	input  logic                 rst,
	input  fp_sincos_pkg::rot_t  rot_i,
	input  logic                 rot_vld_i,
	output fp_sincos_pkg::fp32_t sin_o,
	output fp_sincos_pkg::fp32_t cos_o,
	output logic                 done_o
);
	import fp_sincos_pkg::*;

	// One component after normalization, leading one sits in bit 31 of sig
	typedef struct packed {
		logic        sign;
		logic        zero;
		exp_t        exp;
		logic [31:0] sig;
	} norm_t;

	logic  s1_vld;
	logic  s1_bad;
	norm_t sin_n;
	norm_t cos_n;

	// =========================================================================
	// Shared per-component logic
	// =========================================================================

	// Magnitude, leading-zero count and left shift
	function automatic norm_t normalize(fix_t v, logic neg);
		logic [31:0] mag;
		logic [5:0]  lz;
		norm_t       n;
		mag = v[31] ? 32'(-v) : 32'(v);
		lz  = 6'd32;
		// Lowest to highest, so the last hit is the leading one
		for (int i = 0; i < 32; i++) begin
			if (mag[i])
				lz = 6'(31 - i);
		end
		// A small overshoot past zero flips the sign of the raw component
		n.sign = neg ^ v[31];
		n.zero = (lz == 6'd32);
		// Bit 30 of the magnitude has weight 1, hence 127 + 1 - lz
		n.exp  = exp_t'(9'd128 - {3'd0, lz});
		n.sig  = mag << lz;
		return n;
	endfunction

	// Round to nearest-even on the bits below the 23-bit fraction
	function automatic fp32_t round_pack(norm_t n);
		logic [22:0] frac;
		logic        rnd;
		logic        stk;
		logic        up;
		logic [23:0] sum;
		exp_t        e;
		fp32_t       r;
		frac = n.sig[30:8];
		rnd  = n.sig[7];
		stk  = |n.sig[6:0];
		up   = rnd & (stk | frac[0]);
		sum  = {1'b0, frac} + 24'(up);
		// Carry out means the fraction wrapped to zero, one binade up
		e    = n.exp + exp_t'(sum[23]);
		if (n.zero)
			r = {n.sign, 31'd0};
		else
			r = {n.sign, e, sum[22:0]};
		return r;
	endfunction

	// =========================================================================
	// Two register stages
	// =========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_vld <= 1'b0;
			done_o <= 1'b0;
		end else begin
			s1_vld <= rot_vld_i;
			done_o <= s1_vld;
		end
	end

	always_ff @(posedge clk) begin
		if (rot_vld_i) begin
			s1_bad <= rot_i.invalid;
			sin_n  <= normalize(rot_i.sin_v, rot_i.sin_neg);
			cos_n  <= normalize(rot_i.cos_v, rot_i.cos_neg);
		end
		// Outputs only change with done_o and hold until the next one
		if (s1_vld) begin
			sin_o <= s1_bad ? QNAN : round_pack(sin_n);
			cos_o <= s1_bad ? QNAN : round_pack(cos_n);
		end
	end

endmodule

// ==== logic/cordic_rotator.sv ====
module cordic_rotator (
	input  logic                 clk,
	input  logic                 rst,
	input  fp_sincos_pkg::prep_t prep_i,
	input  logic                 prep_vld_i,
	output fp_sincos_pkg::rot_t  rot_o,
	output logic                 rot_vld_o,
	output logic                 busy_o
);
	import fp_sincos_pkg::*;

	rot_state_e state;
	iter_t      cnt;

	// Vector components and residual angle
	fix_t x_r;
	fix_t y_r;
	fix_t z_r;
	fix_t x_sh;
	fix_t y_sh;

	logic sin_neg_r;
	logic cos_neg_r;
	logic invalid_r;

	// Arithmetic shifts by the iteration index
	assign x_sh = x_r >>> cnt;
	assign y_sh = y_r >>> cnt;

	// =========================================================================
	// Control FSM
	// =========================================================================

	// FINISH lingers for the output stages so that busy covers them too
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= IDLE;
			cnt       <= '0;
			rot_vld_o <= 1'b0;
		end else begin
			rot_vld_o <= 1'b0;
			case (state)
				IDLE: begin
					if (prep_vld_i) begin
						state <= RUN;
						cnt   <= '0;
					end
				end
				RUN: begin
					if (cnt == iter_t'(CORDIC_ITER - 1)) begin
						state     <= FINISH;
						cnt       <= '0;
						rot_vld_o <= 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				FINISH: begin
					if (cnt == iter_t'(PACK_DEPTH))
						state <= IDLE;
					else
						cnt <= cnt + 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// =========================================================================
	// Rotation datapath
	// =========================================================================

	always_ff @(posedge clk) begin
		if (state == IDLE && prep_vld_i) begin
			// Starting at the inverse gain leaves a unit vector at the end
			x_r       <= CORDIC_X0;
			y_r       <= '0;
			z_r       <= prep_i.angle;
			sin_neg_r <= prep_i.sin_neg;
			cos_neg_r <= prep_i.cos_neg;
			invalid_r <= prep_i.invalid;
		end else if (state == RUN) begin
			// Turn toward zero residual angle
			if (!z_r[31]) begin
				x_r <= x_r - y_sh;
				y_r <= y_r + x_sh;
				z_r <= z_r - ATAN_TABLE[cnt];
			end else begin
				x_r <= x_r + y_sh;
				y_r <= y_r - x_sh;
				z_r <= z_r + ATAN_TABLE[cnt];
			end
		end
	end

	// Results stay put from FINISH until the next load
	assign rot_o.sin_v   = y_r;
	assign rot_o.cos_v   = x_r;
	assign rot_o.sin_neg = sin_neg_r;
	assign rot_o.cos_neg = cos_neg_r;
	assign rot_o.invalid = invalid_r;

	assign busy_o = (state != IDLE);

endmodule

// ==== logic/fp_angle_prep.sv ====
module fp_angle_prep (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 ld_i,
	input  fp_sincos_pkg::fp32_t a_i,
	output fp_sincos_pkg::prep_t prep_o,
	output logic                 prep_vld_o
);
	import fp_sincos_pkg::*;

	// Operand fields, split combinationally
	exp_t        a_exp;
	sig_t        a_sig;
	logic [31:0] a_mag;
	logic        a_bad;

	// First stage, magnitude already in unsigned Q2.30
	logic        s1_vld;
	logic        s1_sign;
	logic        s1_bad;
	logic [31:0] s1_mag;

	// Second stage decisions
	logic        over_pi;
	logic        over_half;

	// =========================================================================
	// Stage 1: decompose and convert to fixed point
	// =========================================================================

	always_comb begin
		a_exp = a_i[30:23];
		// Subnormals get no hidden bit, they fall below EXP_ZERO anyway
		a_sig = {a_exp != 8'd0, a_i[22:0]};
		if (a_exp < EXP_ZERO)
			a_mag = '0;
		else if (a_exp >= EXP_FIX0)
			a_mag = {8'd0, a_sig} << (a_exp - EXP_FIX0);
		else
			a_mag = {8'd0, a_sig} >> (EXP_FIX0 - a_exp);
		// Covers infinity and NaN too, since their exponent is all ones
		a_bad = (a_exp > EXP_MAX);
	end

	// =========================================================================
	// Stage 2: range check and fold into the first quadrant
	// =========================================================================

	// Anything above pi is outside the supported range
	assign over_pi = (s1_mag > PI_FIX);
	// sin(pi - a) = sin(a) and cos(pi - a) = -cos(a)
	assign over_half = (s1_mag > $unsigned(HALF_PI_FIX));

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_vld     <= 1'b0;
			prep_vld_o <= 1'b0;
		end else begin
			s1_vld     <= ld_i;
			prep_vld_o <= s1_vld;
		end
	end

	always_ff @(posedge clk) begin
		if (ld_i) begin
			s1_sign <= a_i[31];
			s1_bad  <= a_bad;
			s1_mag  <= a_mag;
		end
		if (s1_vld) begin
			prep_o.invalid <= s1_bad | over_pi;
			// Sine is odd, so its sign follows the operand
			prep_o.sin_neg <= s1_sign;
			// Cosine is even, only the fold flips it
			prep_o.cos_neg <= over_half;
			if (s1_bad || over_pi)
				prep_o.angle <= '0;
			else if (over_half)
				prep_o.angle <= fix_t'(PI_FIX - s1_mag);
			else
				prep_o.angle <= fix_t'(s1_mag);
		end
	end

endmodule

// ==== logic/fp_sincos_pkg.sv ====
package fp_sincos_pkg;

	// =========================================================================
	// Word and field types
	// =========================================================================

	// IEEE binary32 word, sign in bit 31, exponent in 30:23, fraction in 22:0
	typedef logic [31:0] fp32_t;
	typedef logic [7:0] exp_t;
	// Significand including the hidden bit
	typedef logic [23:0] sig_t;
	// Signed Q2.30 fixed point, used for the angle and both vector components
	typedef logic signed [31:0] fix_t;
	// Rotator iteration index
	typedef logic [4:0] iter_t;

	// Angle handed from the input side to the rotator
	typedef struct packed {
		fix_t angle;
		logic sin_neg;
		logic cos_neg;
		logic invalid;
	} prep_t;

	// Raw rotator result with the sign flags carried alongside
	typedef struct packed {
		fix_t sin_v;
		fix_t cos_v;
		logic sin_neg;
		logic cos_neg;
		logic invalid;
	} rot_t;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		FINISH
	} rot_state_e;

	// =========================================================================
	// Format constants
	// =========================================================================

	localparam int FRAC_W = 23;
	localparam int FIX_FRAC = 30;
	localparam int EXP_BIAS = 127;
	// An operand with this exponent lands in Q2.30 without any shift
	localparam exp_t EXP_FIX0 = exp_t'(EXP_BIAS + FRAC_W - FIX_FRAC);
	// Below this the whole significand falls off the bottom of Q2.30
	localparam exp_t EXP_ZERO = exp_t'(EXP_FIX0 - FRAC_W - 1);
	// Largest exponent that still fits the unsigned Q2.30 magnitude
	localparam exp_t EXP_MAX = exp_t'(EXP_BIAS + 1);

	localparam fp32_t QNAN = 32'h7FC0_0000;

	// =========================================================================
	// CORDIC constants, all Q2.30
	// =========================================================================

	localparam int CORDIC_ITER = 30;
	localparam fix_t CORDIC_X0 = 32'sd652032874;
	// Pi does not fit the signed range, so it is kept as an unsigned magnitude
	localparam logic [31:0] PI_FIX = 32'd3373259426;
	localparam fix_t HALF_PI_FIX = 32'sd1686629713;

	// Entry i holds atan(2**-i), from i = 10 on it is just 2**-i
	localparam fix_t ATAN_TABLE [CORDIC_ITER] = '{
		843314857, 497837829, 263043837, 133525159, 67021687,
		33543516, 16775851, 8388437, 4194283, 2097149,
		1048576, 524288, 262144, 131072, 65536,
		32768, 16384, 8192, 4096, 2048,
		1024, 512, 256, 128, 64,
		32, 16, 8, 4, 2
	};

	// Pipeline depths around the rotator
	localparam int PREP_DEPTH = 2;
	localparam int PACK_DEPTH = 2;
	// Load cycle plus one cycle per iteration in the rotator
	localparam int SINCOS_LATENCY = PREP_DEPTH + 1 + CORDIC_ITER + PACK_DEPTH;

endpackage
